// File: hdl/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

`default_nettype none

// Datapath widths
`define DATA_W          32              // Data and address
`define REG_ADDR_W      5               // Register file address
`define WB_CTRL_W       2
`define MEM_CTRL_W      3

// Program counter
`define RESET_PC        32'h0000_0000
`define PC_STEP         4               // Byte step to next instruction

`default_nettype wire

`endif

// File: hdl/ex_pkg.sv
`include "ex_macros.svh"

`default_nettype none

package ex_pkg;

        //////////////////////////////////////////////////
        // Control encodings
        //////////////////////////////////////////////////
        typedef enum logic [1:0] {
                FWD_REG = 2'b00,
                FWD_MEM = 2'b01,
                FWD_WB  = 2'b10,
                FWD_RSV = 2'b11         // Acts as register value
        } fwd_sel_e;

        typedef enum logic [2:0] {
                ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASS2
        } alu_op_e;

        typedef enum logic [1:0] {
                SRC1_RS1  = 2'b00,
                SRC1_PC   = 2'b01,
                SRC1_ZERO = 2'b10
        } src1_e;

        // Codes above GE never take
        typedef enum logic [3:0] {
                COND_AL, COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI,
                COND_PL, COND_VS, COND_VC, COND_LT, COND_GE
        } cond_e;

        typedef struct packed {
                logic n;
                logic z;
                logic c;
                logic v;
        } cc_t;

        //////////////////////////////////////////////////
        // Control word, two decodings
        //////////////////////////////////////////////////
        typedef struct packed {
                alu_op_e alu_op;
                src1_e   src1;
                logic    src2_imm;      // Immediate as operand 2
                logic    cc_we;
                logic    spare;
        } ex_alu_ctrl_t;

        typedef struct packed {
                cond_e      cond;
                logic       jmp;
                logic       bxx;
                logic [1:0] spare;
        } ex_br_ctrl_t;

        typedef union packed {
                ex_alu_ctrl_t alu;
                ex_br_ctrl_t  br;       // Only meaningful with is_branch
        } ex_ctrl_u;

        //////////////////////////////////////////////////
        // Pipeline bundles
        //////////////////////////////////////////////////
        typedef struct packed {
                logic                    valid;
                logic                    is_branch;
                ex_ctrl_u                ctrl;
                logic [`WB_CTRL_W-1:0]   wb_ctrl;
                logic [`MEM_CTRL_W-1:0]  mem_ctrl;
                logic [`DATA_W-1:0]      rs1_val;
                logic [`DATA_W-1:0]      rs2_val;
                logic [`DATA_W-1:0]      imm;
                logic [`REG_ADDR_W-1:0]  rs1_addr;
                logic [`REG_ADDR_W-1:0]  rs2_addr;
                logic [`REG_ADDR_W-1:0]  rds_addr;
                logic [`DATA_W-1:0]      pc;
                logic [`DATA_W-1:0]      ppc;   // Predicted next PC
        } id_ex_t;

        typedef struct packed {
                logic                    valid;
                logic [`WB_CTRL_W-1:0]   wb_ctrl;
                logic [`MEM_CTRL_W-1:0]  mem_ctrl;
                logic [`DATA_W-1:0]      alu_rslt;
                logic [`DATA_W-1:0]      store_val;
                logic [`REG_ADDR_W-1:0]  rs2_addr;
                logic [`REG_ADDR_W-1:0]  rds_addr;
                logic [`DATA_W-1:0]      pc;
        } ex_ma_t;

        typedef struct packed {
                fwd_sel_e           sel1;
                fwd_sel_e           sel2;
                logic [`DATA_W-1:0] mem_data;
                logic [`DATA_W-1:0] wb_data;
        } fwd_t;

        // Bubble PC matches the reset PC
        localparam ex_ma_t EX_MA_BUBBLE = '{
                valid:     1'b0,
                wb_ctrl:   '0,
                mem_ctrl:  '0,
                alu_rslt:  '0,
                store_val: '0,
                rs2_addr:  '0,
                rds_addr:  '0,
                pc:        `RESET_PC
        };

endpackage

`default_nettype wire

// File: hdl/ex_operand_select.sv
`timescale 1ns/1ps

`include "ex_macros.svh"

`default_nettype none

module ex_operand_select import ex_pkg::*; (
        input  id_ex_t                  i_id_ex,
        input  fwd_t                    i_fwd,

        output logic [`DATA_W-1:0]      o_op1,
        output logic [`DATA_W-1:0]      o_op2,
        output logic [`DATA_W-1:0]      o_store_data
);

        logic [`DATA_W-1:0] rs1_fwd;
        logic [`DATA_W-1:0] rs2_fwd;

        // Forwarding mux shared by both register operands
        function automatic logic [`DATA_W-1:0] fwd_pick(
                input fwd_sel_e           sel,
                input logic [`DATA_W-1:0] reg_val,
                input fwd_t               fwd
        );
                logic [`DATA_W-1:0] val;
                case (sel)
                        FWD_MEM: val = fwd.mem_data;
                        FWD_WB:  val = fwd.wb_data;
                        default: val = reg_val;         // Register and reserved code
                endcase
                return val;
        endfunction

        //////////////////////////////////////////////////
        // Forwarded register values
        //////////////////////////////////////////////////
        assign rs1_fwd = fwd_pick(i_fwd.sel1, i_id_ex.rs1_val, i_fwd);
        assign rs2_fwd = fwd_pick(i_fwd.sel2, i_id_ex.rs2_val, i_fwd);

        assign o_store_data = rs2_fwd;          // Store data follows forwarded rs2

        //////////////////////////////////////////////////
        // ALU source selection
        //////////////////////////////////////////////////
        always_comb begin
                if (i_id_ex.is_branch) begin
                        o_op1 = i_id_ex.pc;     // Target is PC plus immediate
                end else begin
                        case (i_id_ex.ctrl.alu.src1)
                                SRC1_PC:   o_op1 = i_id_ex.pc;
                                SRC1_ZERO: o_op1 = '0;
                                default:   o_op1 = rs1_fwd;
                        endcase
                end
        end

        always_comb begin
                if (i_id_ex.is_branch || i_id_ex.ctrl.alu.src2_imm) begin
                        o_op2 = i_id_ex.imm;
                end else begin
                        o_op2 = rs2_fwd;
                end
        end

endmodule

`default_nettype wire

// File: hdl/ex_alu.sv
`timescale 1ns/1ps

`include "ex_macros.svh"

`default_nettype none

module ex_alu import ex_pkg::*; (
        input  logic                    i_clk,
        input  logic                    i_rst_n,

        input  logic [`DATA_W-1:0]      i_op1,
        input  logic [`DATA_W-1:0]      i_op2,
        input  alu_op_e                 i_alu_op,
        input  logic                    i_cc_we,

        output logic [`DATA_W-1:0]      o_rslt,
        output cc_t                     o_ccodes
);

        localparam int MSB     = `DATA_W - 1;
        localparam int SHAMT_W = $clog2(`DATA_W);

        logic [`DATA_W:0]       sum_ext;        // Extra bit holds the carry
        logic                   carry;
        logic                   ovf;
        cc_t                    cc_next;

        //////////////////////////////////////////////////
        // Operation
        //////////////////////////////////////////////////
        always_comb begin
                sum_ext = '0;
                carry   = 1'b0;
                ovf     = 1'b0;
                o_rslt  = '0;
                case (i_alu_op)
                        ALU_ADD: begin
                                sum_ext = {1'b0, i_op1} + {1'b0, i_op2};
                                o_rslt  = sum_ext[MSB:0];
                                carry   = sum_ext[`DATA_W];
                                ovf     = (i_op1[MSB] == i_op2[MSB]) &&
                                          (o_rslt[MSB] != i_op1[MSB]);
                        end
                        ALU_SUB: begin
                                // Add the complement, carry set means no borrow
                                sum_ext = {1'b0, i_op1} + {1'b0, ~i_op2} +
                                          {{`DATA_W{1'b0}}, 1'b1};
                                o_rslt  = sum_ext[MSB:0];
                                carry   = sum_ext[`DATA_W];
                                ovf     = (i_op1[MSB] != i_op2[MSB]) &&
                                          (o_rslt[MSB] != i_op1[MSB]);
                        end
                        ALU_AND:   o_rslt = i_op1 & i_op2;
                        ALU_OR:    o_rslt = i_op1 | i_op2;
                        ALU_XOR:   o_rslt = i_op1 ^ i_op2;
                        ALU_SHL:   o_rslt = i_op1 << i_op2[SHAMT_W-1:0];
                        ALU_SHR:   o_rslt = i_op1 >> i_op2[SHAMT_W-1:0];        // Logical
                        ALU_PASS2: o_rslt = i_op2;
                        default:   o_rslt = '0;
                endcase
        end

        //////////////////////////////////////////////////
        // Condition codes
        //////////////////////////////////////////////////
        always_comb begin
                cc_next.n = o_rslt[MSB];
                cc_next.z = (o_rslt == '0);
                cc_next.c = carry;              // Zero outside ADD and SUB
                cc_next.v = ovf;
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_ccodes <= '0;
                end else if (i_cc_we) begin
                        o_ccodes <= cc_next;
                end
        end

endmodule

`default_nettype wire

// File: hdl/ex_branch_resolve.sv
`timescale 1ns/1ps

`include "ex_macros.svh"

`default_nettype none

module ex_branch_resolve import ex_pkg::*; (
        input  logic                    i_valid,
        input  logic                    i_is_branch,
        input  ex_ctrl_u                i_ctrl,
        input  cc_t                     i_ccodes,
        input  logic [`DATA_W-1:0]      i_pc,
        input  logic [`DATA_W-1:0]      i_ppc,
        input  logic [`DATA_W-1:0]      i_target,

        output logic [`DATA_W-1:0]      o_new_pc,
        output logic                    o_mispredict
);

        logic                   cond_true;
        logic                   taken;
        logic [`DATA_W-1:0]     seq_pc;

        // Condition test on the flags as they stand now
        always_comb begin
                case (i_ctrl.br.cond)
                        COND_AL: cond_true = 1'b1;
                        COND_EQ: cond_true = i_ccodes.z;
                        COND_NE: cond_true = !i_ccodes.z;
                        COND_CS: cond_true = i_ccodes.c;
                        COND_CC: cond_true = !i_ccodes.c;
                        COND_MI: cond_true = i_ccodes.n;
                        COND_PL: cond_true = !i_ccodes.n;
                        COND_VS: cond_true = i_ccodes.v;
                        COND_VC: cond_true = !i_ccodes.v;
                        COND_LT: cond_true = i_ccodes.n ^ i_ccodes.v;
                        COND_GE: cond_true = !(i_ccodes.n ^ i_ccodes.v);
                        default: cond_true = 1'b0;      // Never
                endcase
        end

        assign taken = i_is_branch &&
                       (i_ctrl.br.jmp || (i_ctrl.br.bxx && cond_true));

        assign seq_pc   = i_pc + `DATA_W'(`PC_STEP);
        assign o_new_pc = taken ? i_target : seq_pc;

        // Prediction check only for a live instruction
        assign o_mispredict = i_valid && (o_new_pc != i_ppc);

endmodule

`default_nettype wire

// File: hdl/ex_mem_reg.sv
`timescale 1ns/1ps

`default_nettype none

module ex_mem_reg import ex_pkg::*; (
        input  logic    i_clk,
        input  logic    i_rst_n,

        input  logic    i_stall,
        input  logic    i_flush,

        input  ex_ma_t  i_d,
        output ex_ma_t  o_q
);

        //////////////////////////////////////////////////
        // EX/MA register
        //////////////////////////////////////////////////
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_q <= EX_MA_BUBBLE;
                end else if (i_flush) begin
                        o_q <= EX_MA_BUBBLE;    // Flush wins over stall
                end else if (!i_stall) begin
                        o_q <= i_d;
                end
                // Stall holds the current contents
        end

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
`timescale 1ns/1ps

`include "ex_macros.svh"

`default_nettype none

module ex_stage import ex_pkg::*; (
        input  logic                    i_clk,
        input  logic                    i_rst_n,

        input  id_ex_t                  i_id_ex,        // From ID/EX register
        input  fwd_t                    i_fwd,          // From forwarding unit

        // Hazard unit levels
        input  logic                    i_stall,
        input  logic                    i_flush,

        output ex_ma_t                  o_ex_ma,
        output cc_t                     o_ccodes,
        output logic [`DATA_W-1:0]      o_new_pc,
        output logic                    o_mispredict
);

        logic [`DATA_W-1:0]     alu_op1;
        logic [`DATA_W-1:0]     alu_op2;
        logic [`DATA_W-1:0]     alu_rslt;
        logic [`DATA_W-1:0]     store_data;
        alu_op_e                alu_op;
        logic                   cc_we;
        ex_ma_t                 ex_ma_d;

        //////////////////////////////////////////////////
        // Input side
        //////////////////////////////////////////////////
        ex_operand_select u_opsel (
                .i_id_ex        (i_id_ex),
                .i_fwd          (i_fwd),
                .o_op1          (alu_op1),
                .o_op2          (alu_op2),
                .o_store_data   (store_data)
        );

        //////////////////////////////////////////////////
        // Processing part
        //////////////////////////////////////////////////
        // Branches always add, and never touch the flags
        assign alu_op = i_id_ex.is_branch ? ALU_ADD : i_id_ex.ctrl.alu.alu_op;
        assign cc_we  = i_id_ex.valid && !i_id_ex.is_branch && i_id_ex.ctrl.alu.cc_we;

        ex_alu u_alu (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_op1          (alu_op1),
                .i_op2          (alu_op2),
                .i_alu_op       (alu_op),
                .i_cc_we        (cc_we),
                .o_rslt         (alu_rslt),
                .o_ccodes       (o_ccodes)
        );

        ex_branch_resolve u_branch (
                .i_valid        (i_id_ex.valid),
                .i_is_branch    (i_id_ex.is_branch),
                .i_ctrl         (i_id_ex.ctrl),
                .i_ccodes       (o_ccodes),     // Flags from earlier instructions
                .i_pc           (i_id_ex.pc),
                .i_ppc          (i_id_ex.ppc),
                .i_target       (alu_rslt),
                .o_new_pc       (o_new_pc),
                .o_mispredict   (o_mispredict)
        );

        //////////////////////////////////////////////////
        // Output side
        //////////////////////////////////////////////////
        assign ex_ma_d = '{
                valid:     i_id_ex.valid,
                wb_ctrl:   i_id_ex.wb_ctrl,
                mem_ctrl:  i_id_ex.mem_ctrl,
                alu_rslt:  alu_rslt,
                store_val: store_data,
                rs2_addr:  i_id_ex.rs2_addr,
                rds_addr:  i_id_ex.rds_addr,
                pc:        i_id_ex.pc
        };

        ex_mem_reg u_exma (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_stall        (i_stall),
                .i_flush        (i_flush),
                .i_d            (ex_ma_d),
                .o_q            (o_ex_ma)
        );

endmodule

`default_nettype wire

// File: test/ex_stage_assertions.sv
`timescale 1ns/1ps

`default_nettype none

module ex_stage_assertions import ex_pkg::*; (
        input  logic    i_clk,
        input  logic    i_rst_n,
        input  logic    i_valid,        // Bundle in EX
        input  logic    i_mispredict,
        input  logic    i_stall,
        input  logic    i_flush,
        input  ex_ma_t  i_q             // EX/MA register output
);

        //////////////////////////////////////////////////
        // Branch outputs
        //////////////////////////////////////////////////
        a_no_mispredict_idle: assert property (
                @(posedge i_clk) disable iff (!i_rst_n)
                !i_valid |-> !i_mispredict
        ) else $error("o_mispredict high while valid is low");

        //////////////////////////////////////////////////
        // EX/MA register
        //////////////////////////////////////////////////
        a_stall_holds: assert property (
                @(posedge i_clk) disable iff (!i_rst_n)
                (i_stall && !i_flush) |=> $stable(i_q)
        ) else $error("EX/MA register changed under stall");

        a_flush_bubble: assert property (
                @(posedge i_clk) disable iff (!i_rst_n)
                i_flush |=> !i_q.valid
        ) else $error("EX/MA register valid after flush");   // Stall does not matter here

endmodule

bind ex_stage ex_stage_assertions u_assertions (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (i_id_ex.valid),
        .i_mispredict   (o_mispredict),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_q            (o_ex_ma)
);

`default_nettype wire

// File: test/ex_stage_tb.sv
`timescale 1ns/1ps

`include "ex_macros.svh"

`default_nettype none

module ex_stage_tb import ex_pkg::*;;

        logic                   clk = 1'b0;
        logic                   rst_n;
        id_ex_t                 id_ex;
        fwd_t                   fwd;
        logic                   stall;
        logic                   flush;
        ex_ma_t                 ex_ma;
        cc_t                    ccodes;
        logic [`DATA_W-1:0]     new_pc;
        logic                   mispredict;

        ex_ma_t                 exp_q;          // Expected EX/MA contents
        cc_t                    model_cc;       // Model copy of the flags
        ex_ma_t                 q_new;
        cc_t                    cc_new;
        logic [`DATA_W-1:0]     pc_new;
        logic                   mis_new;
        logic [3:0]             fwd_cnt = '0;
        int                     n_checks = 0;
        int                     n_errors = 0;
        int                     n_failed = 0;

        always #4 clk = ~clk;                   // 8 ns period

        ex_stage UUT (
                .i_clk          (clk),
                .i_rst_n        (rst_n),
                .i_id_ex        (id_ex),
                .i_fwd          (fwd),
                .i_stall        (stall),
                .i_flush        (flush),
                .o_ex_ma        (ex_ma),
                .o_ccodes       (ccodes),
                .o_new_pc       (new_pc),
                .o_mispredict   (mispredict)
        );

        //////////////////////////////////////////////////
        // Reference model
        //////////////////////////////////////////////////
        function automatic logic cond_holds(input cond_e k, input cc_t cc);
                case (k)
                        COND_AL: return 1'b1;
                        COND_EQ: return cc.z;
                        COND_NE: return !cc.z;
                        COND_CS: return cc.c;
                        COND_CC: return !cc.c;
                        COND_MI: return cc.n;
                        COND_PL: return !cc.n;
                        COND_VS: return cc.v;
                        COND_VC: return !cc.v;
                        COND_LT: return cc.n != cc.v;
                        COND_GE: return cc.n == cc.v;
                        default: return 1'b0;
                endcase
        endfunction

        function automatic void ex_model(
                input  id_ex_t             d,
                input  fwd_t               f,
                input  cc_t                cc,
                output ex_ma_t             q,
                output cc_t                cc_nxt,
                output logic [`DATA_W-1:0] npc,
                output logic               mis
        );
                logic [`DATA_W-1:0] rs1;
                logic [`DATA_W-1:0] rs2;
                logic [`DATA_W-1:0] a;
                logic [`DATA_W-1:0] b;
                logic [`DATA_W-1:0] r;
                logic [`DATA_W:0]   wide;
                logic [`DATA_W:0]   sw;         // Sign-extended sum for overflow
                logic               carry;
                logic               ovf;
                alu_op_e            op;

                rs1 = (f.sel1 == FWD_MEM) ? f.mem_data :
                      (f.sel1 == FWD_WB)  ? f.wb_data : d.rs1_val;
                rs2 = (f.sel2 == FWD_MEM) ? f.mem_data :
                      (f.sel2 == FWD_WB)  ? f.wb_data : d.rs2_val;
                if (d.is_branch || d.ctrl.alu.src1 == SRC1_PC) a = d.pc;
                else if (d.ctrl.alu.src1 == SRC1_ZERO) a = '0;
                else a = rs1;
                b = (d.is_branch || d.ctrl.alu.src2_imm) ? d.imm : rs2;
                op = d.is_branch ? ALU_ADD : d.ctrl.alu.alu_op;
                carry = 1'b0;
                ovf = 1'b0;
                case (op)
                        ALU_ADD: begin
                                wide  = {1'b0, a} + {1'b0, b};
                                sw    = {a[31], a} + {b[31], b};
                                r     = wide[31:0];
                                carry = wide[32];
                                ovf   = sw[32] ^ sw[31];
                        end
                        ALU_SUB: begin
                                sw    = {a[31], a} - {b[31], b};
                                r     = a - b;
                                carry = (a >= b);       // No borrow
                                ovf   = sw[32] ^ sw[31];
                        end
                        ALU_AND: r = a & b;
                        ALU_OR:  r = a | b;
                        ALU_XOR: r = a ^ b;
                        ALU_SHL: r = a << b[4:0];
                        ALU_SHR: r = a >> b[4:0];
                        default: r = b;
                endcase
                cc_nxt = cc;
                if (d.valid && !d.is_branch && d.ctrl.alu.cc_we)
                        cc_nxt = '{n: r[31], z: (r == '0), c: carry, v: ovf};
                if (d.is_branch &&
                    (d.ctrl.br.jmp || (d.ctrl.br.bxx && cond_holds(d.ctrl.br.cond, cc))))
                        npc = r;
                else
                        npc = d.pc + `DATA_W'(`PC_STEP);
                mis = d.valid && (npc != d.ppc);
                q = '{valid: d.valid, wb_ctrl: d.wb_ctrl, mem_ctrl: d.mem_ctrl, alu_rslt: r,
                      store_val: rs2, rs2_addr: d.rs2_addr, rds_addr: d.rds_addr, pc: d.pc};
        endfunction

        //////////////////////////////////////////////////
        // Compare process
        //////////////////////////////////////////////////
        task automatic check_val(
                input string       name,
                input logic [31:0] got,
                input logic [31:0] exp
        );
                if (got !== exp) begin
                        $display("Fail t=%0t %s exp=%h got=%h", $time, name, exp, got);
                        n_errors++;
                end
        endtask

        always @(negedge clk) begin
                if (!rst_n) begin
                        exp_q = '0;             // Reset acts at once
                        model_cc = '0;
                end
                ex_model(id_ex, fwd, model_cc, q_new, cc_new, pc_new, mis_new);
                check_val("o_ex_ma.valid", 32'(ex_ma.valid), 32'(exp_q.valid));
                check_val("o_ex_ma.wb_ctrl", 32'(ex_ma.wb_ctrl), 32'(exp_q.wb_ctrl));
                check_val("o_ex_ma.mem_ctrl", 32'(ex_ma.mem_ctrl), 32'(exp_q.mem_ctrl));
                check_val("o_ex_ma.alu_rslt", ex_ma.alu_rslt, exp_q.alu_rslt);
                check_val("o_ex_ma.store_val", ex_ma.store_val, exp_q.store_val);
                check_val("o_ex_ma.rs2_addr", 32'(ex_ma.rs2_addr), 32'(exp_q.rs2_addr));
                check_val("o_ex_ma.rds_addr", 32'(ex_ma.rds_addr), 32'(exp_q.rds_addr));
                check_val("o_ex_ma.pc", ex_ma.pc, exp_q.pc);
                check_val("o_ccodes", 32'(ccodes), 32'(model_cc));
                check_val("o_new_pc", new_pc, pc_new);
                check_val("o_mispredict", 32'(mispredict), 32'(mis_new));
                n_checks++;
                // State after the coming rising edge
                if (!rst_n || flush) exp_q = '0;
                else if (!stall) exp_q = q_new;
                if (rst_n) model_cc = cc_new;
        end

        //////////////////////////////////////////////////
        // Stimulus
        //////////////////////////////////////////////////
        function automatic logic [31:0] edge_value(input int k);
                case (k)
                        0: return 32'h0000_0000;
                        1: return 32'h0000_0001;
                        2: return 32'h7fff_ffff;
                        3: return 32'h8000_0000;
                        4: return 32'hffff_ffff;
                        default: return $urandom;
                endcase
        endfunction

        task automatic drive_cycle(input int mode);
                id_ex_t     d;
                fwd_t       f;
                logic [1:0] guess;

                d.valid = 1'b1;
                d.is_branch = 1'b0;
                d.ctrl = ex_ctrl_u'(8'($urandom));
                d.wb_ctrl = 2'($urandom);
                d.mem_ctrl = 3'($urandom);
                d.rs1_val = $urandom;
                d.rs2_val = $urandom;
                d.imm = $urandom & 32'hffff_fffc;
                d.rs1_addr = 5'($urandom);
                d.rs2_addr = 5'($urandom);
                d.rds_addr = 5'($urandom);
                d.pc = $urandom & 32'hffff_fffc;
                d.ppc = $urandom;
                f.sel1 = fwd_sel_e'(2'($urandom));
                f.sel2 = fwd_sel_e'(2'($urandom));
                f.mem_data = $urandom;
                f.wb_data = $urandom;
                stall = 1'b0;
                flush = 1'b0;
                case (mode)
                        0: d.valid = 1'b0;                      // Idle slot
                        2: begin
                                f.sel1 = fwd_sel_e'(fwd_cnt[1:0]);
                                f.sel2 = fwd_sel_e'(fwd_cnt[3:2]);
                                fwd_cnt = fwd_cnt + 4'd1;       // Walks all sixteen pairs
                                d.ctrl.alu.src1 = SRC1_RS1;
                        end
                        3, 4: begin
                                d.valid = (mode == 4) || ($urandom_range(0, 3) != 0);
                                d.is_branch = (mode == 4) ? 1'($urandom)
                                                          : ($urandom_range(0, 3) == 0);
                                if (!d.is_branch) begin
                                        d.ctrl.alu.alu_op = 1'($urandom) ? ALU_SUB : ALU_ADD;
                                        if ($urandom_range(0, 7) == 0)
                                                d.ctrl.alu.alu_op = alu_op_e'(3'($urandom));
                                        d.ctrl.alu.src1 = SRC1_RS1;
                                        d.ctrl.alu.src2_imm = 1'b0;
                                        d.ctrl.alu.cc_we = (mode == 4) || 1'($urandom);
                                        f.sel1 = FWD_REG;
                                        f.sel2 = FWD_REG;
                                        d.rs1_val = edge_value($urandom_range(0, 5));
                                        d.rs2_val = edge_value($urandom_range(0, 5));
                                end else begin
                                        guess = 2'($urandom);   // Right and wrong predictions
                                        if (guess == 2'd0) d.ppc = d.pc + `DATA_W'(`PC_STEP);
                                        else if (guess == 2'd1) d.ppc = d.pc + d.imm;
                                end
                        end
                        5: begin
                                d.valid = 1'($urandom);
                                d.is_branch = 1'($urandom);
                                stall = 1'($urandom);
                                flush = ($urandom_range(0, 4) == 0);
                        end
                        default: ;
                endcase
                id_ex = d;
                fwd = f;
        endtask

        task automatic drive_cycles(input int mode, input int cycles);
                for (int i = 0; i < cycles; i++) begin
                        @(posedge clk);
                        #1;
                        drive_cycle(mode);
                end
        endtask

        task automatic wait_checks(input int n);
                int target;
                int guard;

                target = n_checks + n;
                guard = 0;
                while (n_checks < target && guard < 20) begin
                        @(posedge clk);
                        guard++;
                end
                if (n_checks < target) begin
                        $display("Timeout: compare process stopped checking outputs");
                        n_errors++;
                end
        endtask

        task automatic report_test(input int id, input string name, input int errs);
                $display("Test %0d %s: %s, %0d errors", id, name,
                         (errs == 0) ? "ok" : "bad", errs);
                if (errs != 0) n_failed++;
        endtask

        task automatic run_test(input int id, input string name, input int mode, input int cycles);
                int errs_before;

                errs_before = n_errors;
                drive_cycles(mode, cycles);
                wait_checks(2);
                report_test(id, name, n_errors - errs_before);
        endtask

        task automatic run_reset_test(input int id);
                int errs_before;

                errs_before = n_errors;
                drive_cycles(5, 40);
                @(posedge clk);
                #1;
                rst_n = 1'b0;                   // Reset in the middle of traffic
                drive_cycle(0);
                drive_cycles(0, 1);
                @(posedge clk);
                #1;
                rst_n = 1'b1;
                drive_cycle(0);
                drive_cycles(0, 3);
                drive_cycles(5, 40);
                wait_checks(2);
                report_test(id, "reset_midrun", n_errors - errs_before);
        endtask

        // Watchdog for the whole run
        initial begin
                #200000;
                $display("Timeout: run did not complete in time");
                $display("Simulation finished: FAIL");
                $finish;
        end

        initial begin
                void'($urandom(82914));
                rst_n = 1'b0;
                stall = 1'b0;
                flush = 1'b0;
                id_ex = '0;
                fwd = '0;
                repeat (2) @(posedge clk);
                #1;
                rst_n = 1'b1;
                run_test(1, "alu_ops", 1, 300);
                run_test(2, "forwarding", 2, 200);
                run_test(3, "cond_codes", 3, 300);
                run_test(4, "branches", 4, 400);
                run_test(5, "stall_flush", 5, 300);
                run_reset_test(6);
                $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors",
                         n_failed, n_checks, n_errors);
                if (n_errors == 0 && n_failed == 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_operand_select.sv
hdl/ex_alu.sv
hdl/ex_branch_resolve.sv
hdl/ex_mem_reg.sv
hdl/ex_stage.sv
test/ex_stage_assertions.sv
test/ex_stage_tb.sv

// File: Makefile
TOP = ex_stage_tb
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) \
		--Mdir $(OBJ) -o $(TOP)
	-./$(OBJ)/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Result: simulation failed"; \
		exit 1; \
	elif ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "Result: run ended without a result line"; \
		exit 1; \
	else \
		echo "Result: simulation passed"; \
	fi

clean:
	rm -rf $(OBJ) sim.log
